/* src/ice_bus_pkg.sv */
package ice_bus_pkg;

	// Character on the receive, transmit and master bus
	typedef logic [7:0] char_t;

	// Mailbox word with the end-of-frame flag in bit 8
	typedef logic [8:0] word_t;

	// Number of mailbox devices on the bus
	localparam int NUM_DEV = 2;

	// Words per mailbox ring buffer
	localparam int MBOX_DEPTH = 32;

	// Ring buffer pointer or read offset from the tail
	typedef logic [$clog2(MBOX_DEPTH)-1:0] ptr_t;

	// Device k answers to DEV_BASE_ADDR + k
	localparam char_t DEV_BASE_ADDR = 8'h10;

endpackage

/* src/ice_ctrl_pkg.sv */
package ice_ctrl_pkg;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_ID,
		RX_LEN,
		RX_PYLD,
		RX_OVERFLOW
	} rx_state_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_GETLEN,
		TX_HEADER_PRE,
		TX_HEADER,
		TX_LEN,
		TX_PAYLOAD,
		TX_LATCH_TAIL
	} tx_state_t;

endpackage

/* src/frame_rx.sv */
`timescale 1ns/10ps

module frame_rx (
	input  logic               clk,
	input  logic               rst,
	input  ice_bus_pkg::char_t rx_char,
	input  logic               rx_char_valid,
	input  logic               sl_overflow,
	output ice_bus_pkg::char_t ma_addr,
	output ice_bus_pkg::char_t ma_data,
	output logic               ma_frame_valid,
	output logic               ma_data_valid,
	output ice_bus_pkg::char_t evt_id,
	output logic               generate_nak
);
	import ice_bus_pkg::*;
	import ice_ctrl_pkg::*;

	rx_state_t state;
	rx_state_t next_state;
	char_t     payload_len;
	char_t     byte_cnt;
	logic      record_addr;
	logic      record_id;
	logic      load_len;
	logic      count_byte;

	// The master bus carries the live receive character
	assign ma_data = rx_char;

	always_comb begin
		next_state = state;
		record_addr = 1'b0;
		record_id = 1'b0;
		load_len = 1'b0;
		count_byte = 1'b0;
		ma_frame_valid = 1'b0;
		ma_data_valid = 1'b0;
		generate_nak = 1'b0;
		case (state)
			RX_IDLE: begin
				// First character of a frame is the device address
				ma_frame_valid = rx_char_valid;
				record_addr = rx_char_valid;
				if (rx_char_valid)
					next_state = RX_ID;
			end
			RX_ID: begin
				ma_frame_valid = 1'b1;
				ma_data_valid = rx_char_valid;
				record_id = rx_char_valid;
				if (rx_char_valid)
					next_state = RX_LEN;
			end
			RX_LEN: begin
				ma_frame_valid = 1'b1;
				ma_data_valid = rx_char_valid;
				load_len = rx_char_valid;
				if (rx_char_valid)
					next_state = (rx_char == 8'd0) ? RX_IDLE : RX_PYLD;
			end
			RX_PYLD: begin
				ma_frame_valid = 1'b1;
				ma_data_valid = rx_char_valid;
				count_byte = rx_char_valid;
				if (sl_overflow)
					next_state = RX_OVERFLOW;
				else if (rx_char_valid && (byte_cnt + 8'd1) == payload_len)
					next_state = RX_IDLE;
			end
			RX_OVERFLOW: begin
				// Frame dropped by a mailbox
				generate_nak = 1'b1;
				next_state = RX_IDLE;
			end
			default: next_state = RX_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= RX_IDLE;
			byte_cnt <= '0;
		end else begin
			state <= next_state;
			if (load_len)
				byte_cnt <= '0;
			else if (count_byte)
				byte_cnt <= byte_cnt + 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (record_addr)
			ma_addr <= rx_char;
		if (record_id)
			evt_id <= rx_char;
		if (load_len)
			payload_len <= rx_char;
	end

	// One NAK trigger per discarded frame
	assert property (@(posedge clk) disable iff (rst) generate_nak |=> !generate_nak);

endmodule

/* src/frame_mailbox.sv */
`timescale 1ns/10ps

module frame_mailbox #(
	parameter ice_bus_pkg::char_t DEV_ADDR = ice_bus_pkg::DEV_BASE_ADDR
) (
	input  logic               clk,
	input  logic               rst,
	input  ice_bus_pkg::char_t ma_addr,
	input  ice_bus_pkg::char_t ma_data,
	input  logic               ma_frame_valid,
	input  logic               ma_data_valid,
	input  ice_bus_pkg::ptr_t  rd_offset,
	input  logic               sl_grant,
	input  logic               sl_latch_tail,
	output ice_bus_pkg::word_t sl_data,
	output logic               sl_arb_request,
	output logic               sl_overflow
);
	import ice_bus_pkg::*;

	word_t      mem [MBOX_DEPTH];
	ptr_t       head;
	ptr_t       tail;
	ptr_t       frame_start;
	ptr_t       gap;
	ptr_t       rd_addr;
	char_t      pending;
	logic [1:0] field;
	logic       active;
	logic       id_push;
	logic       pyld_push;
	logic       room_short;
	logic       commit;
	logic       wr_en;
	word_t      wr_word;

	// Free distance from head to tail, zero when the buffer is empty
	assign gap = tail - head;
	// Each push must leave a slot for the deferred last word
	assign room_short = (gap == ptr_t'(1)) || (gap == ptr_t'(2));

	// Field 0 is the event id, 1 the length, 2 the payload
	assign id_push = ma_frame_valid && ma_data_valid && field == 2'd0 && ma_addr == DEV_ADDR;
	assign pyld_push = active && ma_frame_valid && ma_data_valid && field == 2'd2;
	assign commit = active && !ma_frame_valid;

	assign sl_overflow = (id_push || pyld_push) && room_short;
	assign sl_arb_request = frame_start != tail;
	assign rd_addr = tail + rd_offset;

	always_comb begin
		wr_en = 1'b0;
		wr_word = {1'b0, pending};
		if (id_push) begin
			// Address word goes in as the event id arrives
			wr_en = !room_short;
			wr_word = {1'b0, ma_addr};
		end else if (pyld_push) begin
			wr_en = !room_short;
		end else if (commit) begin
			wr_en = 1'b1;
			wr_word = {1'b1, pending};
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[head] <= wr_word;
		if ((id_push || pyld_push) && !room_short)
			pending <= ma_data;
		sl_data <= mem[rd_addr];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			frame_start <= '0;
			field <= '0;
			active <= 1'b0;
		end else begin
			if (!ma_frame_valid)
				field <= '0;
			else if (ma_data_valid && field != 2'd2)
				field <= field + 2'd1;

			if (wr_en)
				head <= head + 1'b1;
			if (id_push && !room_short)
				active <= 1'b1;
			if (pyld_push && room_short) begin
				// Drop the partial frame
				active <= 1'b0;
				head <= frame_start;
			end
			if (commit) begin
				active <= 1'b0;
				frame_start <= head + 1'b1;
			end

			if (sl_grant && sl_latch_tail)
				tail <= tail + rd_offset;
		end
	end

endmodule

/* src/priority_select.sv */
`timescale 1ns/10ps

module priority_select (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [ice_bus_pkg::NUM_DEV-1:0] requests,
	input  logic                           release_grant,
	output logic [ice_bus_pkg::NUM_DEV-1:0] grants,
	output logic                           granted
);
	import ice_bus_pkg::*;

	logic [NUM_DEV-1:0] pick;

	// Lowest index wins
	always_comb begin
		pick = '0;
		for (int i = NUM_DEV - 1; i >= 0; i--) begin
			if (requests[i]) begin
				pick = '0;
				pick[i] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			grants <= '0;
			granted <= 1'b0;
		end else if (granted) begin
			if (release_grant) begin
				grants <= '0;
				granted <= 1'b0;
			end
		end else if (|requests) begin
			grants <= pick;
			granted <= 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		$onehot0(grants) && (granted == |grants));

endmodule

/* src/frame_tx.sv */
`timescale 1ns/10ps

module frame_tx (
	input  logic                                         clk,
	input  logic                                         rst,
	input  logic                                         granted,
	input  logic [ice_bus_pkg::NUM_DEV-1:0]               sl_arb_grant,
	input  ice_bus_pkg::word_t [ice_bus_pkg::NUM_DEV-1:0] sl_data_all,
	output ice_bus_pkg::ptr_t                            rd_offset,
	output logic                                         sl_latch_tail,
	output ice_bus_pkg::char_t                           tx_char,
	output logic                                         tx_char_valid,
	input  logic                                         tx_char_ready
);
	import ice_bus_pkg::*;
	import ice_ctrl_pkg::*;

	tx_state_t state;
	tx_state_t next_state;
	ptr_t      offset;
	char_t     len_save;
	logic      save_len;
	logic      send_len;
	word_t     cur_word;

	// Word from the granted mailbox only
	always_comb begin
		cur_word = '0;
		for (int i = 0; i < NUM_DEV; i++) begin
			if (sl_arb_grant[i])
				cur_word = cur_word | sl_data_all[i];
		end
	end

	assign tx_char = send_len ? len_save : cur_word[7:0];

	// rd_offset is the next offset so read data lines up with offset
	always_comb begin
		next_state = state;
		rd_offset = offset;
		save_len = 1'b0;
		send_len = 1'b0;
		tx_char_valid = 1'b0;
		sl_latch_tail = 1'b0;
		case (state)
			TX_IDLE: begin
				rd_offset = '0;
				if (granted)
					next_state = TX_GETLEN;
			end
			TX_GETLEN: begin
				if (cur_word[8]) begin
					save_len = 1'b1;
					rd_offset = '0;
					next_state = TX_HEADER_PRE;
				end else begin
					rd_offset = offset + 1'b1;
				end
			end
			TX_HEADER_PRE: begin
				rd_offset = '0;
				next_state = TX_HEADER;
			end
			TX_HEADER: begin
				tx_char_valid = tx_char_ready;
				if (tx_char_ready) begin
					rd_offset = offset + 1'b1;
					if (offset == ptr_t'(1))
						next_state = TX_LEN;
				end
			end
			TX_LEN: begin
				send_len = 1'b1;
				tx_char_valid = tx_char_ready;
				if (tx_char_ready)
					next_state = (len_save == '0) ? TX_LATCH_TAIL : TX_PAYLOAD;
			end
			TX_PAYLOAD: begin
				tx_char_valid = tx_char_ready;
				if (tx_char_ready) begin
					rd_offset = offset + 1'b1;
					if (cur_word[8])
						next_state = TX_LATCH_TAIL;
				end
			end
			TX_LATCH_TAIL: begin
				// Offset now holds the word count of the frame
				sl_latch_tail = 1'b1;
				next_state = TX_IDLE;
			end
			default: next_state = TX_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= TX_IDLE;
			offset <= '0;
		end else begin
			state <= next_state;
			offset <= rd_offset;
		end
	end

	// Flag at word f gives f - 1 payload bytes
	always_ff @(posedge clk) begin
		if (save_len)
			len_save <= char_t'(offset) - 8'd1;
	end

	assert property (@(posedge clk) disable iff (rst)
		tx_char_valid |-> tx_char_ready && granted);

endmodule

/* src/ice_bus_top.sv */
`timescale 1ns/10ps

module ice_bus_top (
	input  logic               clk,
	input  logic               rst,
	input  ice_bus_pkg::char_t rx_char,
	input  logic               rx_char_valid,
	output ice_bus_pkg::char_t tx_char,
	output logic               tx_char_valid,
	input  logic               tx_char_ready,
	output logic               generate_nak,
	output ice_bus_pkg::char_t evt_id
);
	import ice_bus_pkg::*;

	char_t                ma_addr;
	char_t                ma_data;
	logic                 ma_frame_valid;
	logic                 ma_data_valid;
	logic                 sl_overflow;
	logic [NUM_DEV-1:0]   ovf_vec;
	logic [NUM_DEV-1:0]   sl_arb_request;
	logic [NUM_DEV-1:0]   sl_arb_grant;
	logic                 granted;
	ptr_t                 rd_offset;
	logic                 sl_latch_tail;
	word_t [NUM_DEV-1:0]  sl_data_all;

	assign sl_overflow = |ovf_vec;

	frame_rx u_rx (
		.clk            (clk),
		.rst            (rst),
		.rx_char        (rx_char),
		.rx_char_valid  (rx_char_valid),
		.sl_overflow    (sl_overflow),
		.ma_addr        (ma_addr),
		.ma_data        (ma_data),
		.ma_frame_valid (ma_frame_valid),
		.ma_data_valid  (ma_data_valid),
		.evt_id         (evt_id),
		.generate_nak   (generate_nak)
	);

	for (genvar i = 0; i < NUM_DEV; i++) begin : g_mbox
		frame_mailbox #(
			.DEV_ADDR (char_t'(DEV_BASE_ADDR + i))
		) u_mbox (
			.clk            (clk),
			.rst            (rst),
			.ma_addr        (ma_addr),
			.ma_data        (ma_data),
			.ma_frame_valid (ma_frame_valid),
			.ma_data_valid  (ma_data_valid),
			.rd_offset      (rd_offset),
			.sl_grant       (sl_arb_grant[i]),
			.sl_latch_tail  (sl_latch_tail),
			.sl_data        (sl_data_all[i]),
			.sl_arb_request (sl_arb_request[i]),
			.sl_overflow    (ovf_vec[i])
		);
	end

	priority_select u_arb (
		.clk           (clk),
		.rst           (rst),
		.requests      (sl_arb_request),
		.release_grant (sl_latch_tail),
		.grants        (sl_arb_grant),
		.granted       (granted)
	);

	frame_tx u_tx (
		.clk           (clk),
		.rst           (rst),
		.granted       (granted),
		.sl_arb_grant  (sl_arb_grant),
		.sl_data_all   (sl_data_all),
		.rd_offset     (rd_offset),
		.sl_latch_tail (sl_latch_tail),
		.tx_char       (tx_char),
		.tx_char_valid (tx_char_valid),
		.tx_char_ready (tx_char_ready)
	);

endmodule

/* test/tb_ice_bus.sv */
`timescale 1ns/10ps

module tb_ice_bus;
	import ice_bus_pkg::*;

	localparam int WAIT_LIMIT = 2000;

	logic   clk = 1'b0;
	logic   rst;
	char_t  rx_char;
	logic   rx_char_valid;
	char_t  tx_char;
	logic   tx_char_valid;
	logic   tx_char_ready;
	logic   generate_nak;
	char_t  evt_id;

	integer seed;
	char_t  tx_q [$];
	int     rd_idx;

	ice_bus_top DUT (
		.clk           (clk),
		.rst           (rst),
		.rx_char       (rx_char),
		.rx_char_valid (rx_char_valid),
		.tx_char       (tx_char),
		.tx_char_valid (tx_char_valid),
		.tx_char_ready (tx_char_ready),
		.generate_nak  (generate_nak),
		.evt_id        (evt_id)
	);

	always #4 clk = ~clk;

	// Every transferred character, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst && tx_char_valid)
			tx_q.push_back(tx_char);
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// Payload content is a fixed pattern of event id and byte index
	function automatic char_t payload_byte(input char_t id, input int idx);
		return char_t'(id * 8'd5 + char_t'(idx) * 8'd7 + 8'h21);
	endfunction

	task automatic drive_char(input char_t c);
		@(posedge clk);
		rx_char <= c;
		rx_char_valid <= 1'b1;
	endtask

	task automatic set_ready(input logic v);
		@(posedge clk);
		tx_char_ready <= v;
	endtask

	task automatic send_frame(input char_t addr, input char_t id, input char_t len);
		int i;
		drive_char(addr);
		drive_char(id);
		drive_char(len);
		for (i = 0; i < int'(len); i++)
			drive_char(payload_byte(id, i));
		@(posedge clk);
		rx_char_valid <= 1'b0;
		@(posedge clk);
		@(negedge clk);
	endtask

	// Waits for a whole frame on tx, optionally with random back-pressure
	task automatic expect_frame(input char_t addr, input char_t id, input char_t len,
			input bit bp);
		int          cycles;
		int          i;
		logic [31:0] r;
		char_t       exp_char;
		cycles = 0;
		while (tx_q.size() < rd_idx + int'(len) + 3) begin
			@(posedge clk);
			if (bp) begin
				r = $random(seed);
				tx_char_ready <= r[0];
			end
			cycles++;
			if (cycles > WAIT_LIMIT)
				fail_run($sformatf("Timed out waiting for the frame to address 0x%0h", addr));
		end
		if (bp)
			set_ready(1'b1);
		for (i = 0; i < int'(len) + 3; i++) begin
			if (i == 0)
				exp_char = addr;
			else if (i == 1)
				exp_char = id;
			else if (i == 2)
				exp_char = len;
			else
				exp_char = payload_byte(id, i - 3);
			check("tx_char", 32'(tx_q[rd_idx + i]), 32'(exp_char));
		end
		rd_idx += int'(len) + 3;
	endtask

	task automatic expect_silence(input int n);
		repeat (n) @(posedge clk);
		check("tx character count", tx_q.size(), rd_idx);
	endtask

	task automatic test_echo();
		send_frame(8'h10, 8'h3c, 8'd4);
		check("evt_id", 32'(evt_id), 32'h3c);
		expect_frame(8'h10, 8'h3c, 8'd4, 1'b0);
	endtask

	task automatic test_zero_length();
		send_frame(8'h11, 8'h5a, 8'd0);
		expect_frame(8'h11, 8'h5a, 8'd0, 1'b0);
	endtask

	// Two frames queue in device 1 while device 0 gets one later
	task automatic test_arbitration();
		set_ready(1'b0);
		send_frame(8'h11, 8'ha1, 8'd3);
		send_frame(8'h11, 8'hb2, 8'd2);
		send_frame(8'h10, 8'hc3, 8'd4);
		expect_silence(20);
		set_ready(1'b1);
		expect_frame(8'h11, 8'ha1, 8'd3, 1'b0);
		expect_frame(8'h10, 8'hc3, 8'd4, 1'b0);
		expect_frame(8'h11, 8'hb2, 8'd2, 1'b0);
	endtask

	task automatic test_backpressure();
		send_frame(8'h10, 8'h77, 8'd10);
		expect_frame(8'h10, 8'h77, 8'd10, 1'b1);
	endtask

	task automatic test_overflow();
		int sent;
		bit nak_seen;
		sent = 0;
		nak_seen = 1'b0;
		drive_char(8'h10);
		drive_char(8'h66);
		drive_char(8'd40);
		while (!nak_seen) begin
			if (sent >= 40)
				fail_run("No NAK pulse during a 40-byte frame to device 0");
			drive_char(payload_byte(8'h66, sent));
			sent++;
			@(negedge clk);
			nak_seen = generate_nak;
		end
		@(posedge clk);
		rx_char_valid <= 1'b0;
		expect_silence(100);
		send_frame(8'h10, 8'h99, 8'd5);
		expect_frame(8'h10, 8'h99, 8'd5, 1'b0);
	endtask

	task automatic test_unknown_address();
		send_frame(8'h20, 8'h44, 8'd3);
		expect_silence(200);
		send_frame(8'h11, 8'h45, 8'd2);
		expect_frame(8'h11, 8'h45, 8'd2, 1'b0);
	endtask

	initial begin
		rst = 1'b1;
		rx_char = '0;
		rx_char_valid = 1'b0;
		tx_char_ready = 1'b1;
		seed = 32'hf04c2fb2;
		rd_idx = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check("tx_char_valid", 32'(tx_char_valid), 32'h0);
		check("generate_nak", 32'(generate_nak), 32'h0);

		test_echo();
		test_zero_length();
		test_arbitration();
		test_backpressure();
		test_overflow();
		test_unknown_address();

		$display("Test passed");
		$finish;
	end

endmodule

/* build.f */
src/ice_bus_pkg.sv
src/ice_ctrl_pkg.sv
src/frame_rx.sv
src/frame_mailbox.sv
src/priority_select.sv
src/frame_tx.sv
src/ice_bus_top.sv
test/tb_ice_bus.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module tb_ice_bus -Mdir obj_dir -o tb_ice_bus -f build.f

run: compile
	./obj_dir/tb_ice_bus

clean:
	rm -rf obj_dir
